// ==== rtl/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// plane units and line buffer size
`define NUM_PLANES 2
`define LINE_W 256

// raster counter widths
`define COL_W 9
`define ROW_W 3

// horizontal raster, in pixels
`define H_TOTAL 300
`define H_SYNC_BEG 270
`define H_SYNC_LEN 16

// vertical raster, short frame
`define V_TOTAL 6
`define V_ACTIVE 4
`define V_SYNC_LINE 5

`define PORT_AW 4

`endif

// ==== rtl/video_cfg_pkg.sv ====
`include "video_settings.svh"

package video_cfg_pkg;

  typedef logic [`PORT_AW-1:0] port_addr_t;

  // port map
  localparam port_addr_t PORT_BORDER = 4'd0;
  localparam port_addr_t PORT_PLANE_BASE = 4'd2;

  // control register layout
  localparam int CTRL_EN_BIT = 7;

  typedef struct packed {
    logic [7:0] x_offs;
    logic       enable;
    logic [3:0] palsel;
  } plane_cfg_t;

  // two registers per plane, scroll first
  function automatic port_addr_t scroll_port(int plane);
    return port_addr_t'(PORT_PLANE_BASE + 2 * plane);
  endfunction

  function automatic port_addr_t ctrl_port(int plane);
    return port_addr_t'(PORT_PLANE_BASE + 2 * plane + 1);
  endfunction

endpackage

// ==== rtl/video_pix_pkg.sv ====
package video_pix_pkg;

  // only the low nibble comes from a plane buffer
  typedef logic [7:0] pix_idx_t;

  localparam logic [3:0] PIX_TRANSPARENT = 4'h0;

  typedef struct packed {
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;
  } rgb15_t;

endpackage

// ==== rtl/video_timing_if.sv ====
`include "video_settings.svh"

interface video_timing_if;

  logic [`COL_W-1:0] col;
  logic [`ROW_W-1:0] row;
  logic              hvpix;
  logic              line_start;

  modport src (
    output col,
    output row,
    output hvpix,
    output line_start
  );

  modport dst (
    input col,
    input row,
    input hvpix,
    input line_start
  );

endinterface

// ==== rtl/video_dpram.sv ====
module video_dpram #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  T                         wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output T                         rdata
);

  T mem [DEPTH];

  // read of an address written in the same cycle returns the old entry
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

// ==== rtl/video_sync.sv ====
`include "video_settings.svh"

module video_sync (
  input  logic           clk,
  input  logic           rst,
  video_timing_if.src    tim,
  output logic           hsync,
  output logic           vsync
);

  localparam logic [`COL_W-1:0] COL_LAST = `COL_W'(`H_TOTAL - 1);
  localparam logic [`ROW_W-1:0] ROW_LAST = `ROW_W'(`V_TOTAL - 1);
  localparam logic [`COL_W-1:0] HS_BEG = `COL_W'(`H_SYNC_BEG);
  localparam logic [`COL_W-1:0] HS_END = `COL_W'(`H_SYNC_BEG + `H_SYNC_LEN);

  logic [`COL_W-1:0] col;
  logic [`ROW_W-1:0] row;

  always_ff @(posedge clk) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else if (col == COL_LAST) begin
      col <= '0;
      if (row == ROW_LAST) begin
        row <= '0;
      end else begin
        row <= row + 1'b1;
      end
    end else begin
      col <= col + 1'b1;
    end
  end

  assign tim.col = col;
  assign tim.row = row;

  // active area: full line buffer width, first rows only
  assign tim.hvpix = (col < `COL_W'(`LINE_W)) && (row < `ROW_W'(`V_ACTIVE));
  assign tim.line_start = (col == '0);

  // raw sync levels, realigned in the mixer
  assign hsync = (col >= HS_BEG) && (col < HS_END);
  assign vsync = (row == `ROW_W'(`V_SYNC_LINE));

endmodule

// ==== rtl/video_ports.sv ====
`include "video_settings.svh"

module video_ports
  import video_cfg_pkg::*;
  import video_pix_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          port_wr,
  input  port_addr_t                    port_a,
  input  logic [7:0]                    d,
  input  logic                          lbuf_we,
  input  logic [8:0]                    zma,
  input  logic [15:0]                   zmd,
  output pix_idx_t                      border,
  output plane_cfg_t [`NUM_PLANES-1:0]  cfg,
  output logic [`NUM_PLANES-1:0]        lb_we,
  output logic [7:0]                    lb_addr,
  output pix_idx_t                      lb_data
);

  always_ff @(posedge clk) begin
    if (rst) begin
      border <= '0;
      cfg <= '0;
    end else if (port_wr) begin
      if (port_a == PORT_BORDER) begin
        border <= d;
      end
      for (int i = 0; i < `NUM_PLANES; i++) begin
        if (port_a == scroll_port(i)) begin
          cfg[i].x_offs <= d;
        end
        // enable and palette select share one register
        if (port_a == ctrl_port(i)) begin
          cfg[i].enable <= d[CTRL_EN_BIT];
          cfg[i].palsel <= d[3:0];
        end
      end
    end
  end

  // zma[8] picks the plane buffer
  always_comb begin
    lb_we = '0;
    if (lbuf_we) begin
      lb_we[zma[8]] = 1'b1;
    end
  end

  assign lb_addr = zma[7:0];
  assign lb_data = pix_idx_t'(zmd[7:0]);

endmodule

// ==== rtl/video_plane.sv ====
`include "video_settings.svh"

module video_plane
  import video_cfg_pkg::*;
  import video_pix_pkg::*;
#(
  parameter int PLANE_ID = 0
) (
  input  logic        clk,
  input  logic        rst,
  video_timing_if.dst tim,
  input  plane_cfg_t  cfg,
  input  logic        lb_we,
  input  logic [7:0]  lb_addr,
  input  pix_idx_t    lb_data,
  output pix_idx_t    pix,
  output logic        hit
);

  // priority comes from the position in the mixer's plane array
  if (PLANE_ID >= `NUM_PLANES) begin : g_bad_id
    $error("video_plane: PLANE_ID beyond NUM_PLANES");
  end

  plane_cfg_t cfg_q;
  plane_cfg_t cfg_cur;
  logic [7:0] raddr;
  pix_idx_t   rdata;
  logic       en_d;
  logic       hvpix_d;
  logic [3:0] palsel_d;

  // new config already applies to column 0
  assign cfg_cur = tim.line_start ? cfg : cfg_q;

  // wraps at 256
  assign raddr = tim.col[7:0] + cfg_cur.x_offs;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
      en_d <= 1'b0;
      hvpix_d <= 1'b0;
    end else begin
      if (tim.line_start) begin
        cfg_q <= cfg;
      end
      en_d <= cfg_cur.enable;
      hvpix_d <= tim.hvpix;
    end
  end

  always_ff @(posedge clk) begin
    palsel_d <= cfg_cur.palsel;
  end

  video_dpram #(
    .T     (pix_idx_t),
    .DEPTH (`LINE_W)
  ) i_lbuf (
    .clk   (clk),
    .we    (lb_we),
    .waddr (lb_addr),
    .wdata (lb_data),
    .raddr (raddr),
    .rdata (rdata)
  );

  // aligned with the buffer read
  assign hit = en_d && hvpix_d && (rdata[3:0] != PIX_TRANSPARENT);
  assign pix = {palsel_d, rdata[3:0]};

endmodule

// ==== rtl/video_mix.sv ====
`include "video_settings.svh"

module video_mix
  import video_pix_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  video_timing_if.dst                 tim,
  input  pix_idx_t [`NUM_PLANES-1:0]  pix,
  input  logic [`NUM_PLANES-1:0]      hit,
  input  pix_idx_t                    border,
  input  logic                        hsync_in,
  input  logic                        vsync_in,
  input  logic                        cram_we,
  input  logic [7:0]                  cram_addr,
  input  rgb15_t                      cram_data,
  output rgb15_t                      rgb,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        blank
);

  pix_idx_t sel;
  pix_idx_t border_q;
  rgb15_t   cram_rdata;
  logic     hvpix_d1;
  logic     hvpix_d2;
  logic     hs_d1;
  logic     hs_d2;
  logic     vs_d1;
  logic     vs_d2;

  // walk down so the lowest plane wins
  always_comb begin
    sel = border_q;
    for (int i = `NUM_PLANES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel = pix[i];
      end
    end
  end

  video_dpram #(
    .T     (rgb15_t),
    .DEPTH (256)
  ) i_cram (
    .clk   (clk),
    .we    (cram_we),
    .waddr (cram_addr),
    .wdata (cram_data),
    .raddr (sel),
    .rdata (cram_rdata)
  );

  // stage 1 planes, stage 2 colour RAM, stage 3 output
  always_ff @(posedge clk) begin
    if (rst) begin
      border_q <= '0;
      hvpix_d1 <= 1'b0;
      hvpix_d2 <= 1'b0;
      hs_d1 <= 1'b0;
      hs_d2 <= 1'b0;
      vs_d1 <= 1'b0;
      vs_d2 <= 1'b0;
      rgb <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      blank <= 1'b0;
    end else begin
      // border held for the whole line, like the plane configs
      if (tim.line_start) begin
        border_q <= border;
      end
      hvpix_d1 <= tim.hvpix;
      hvpix_d2 <= hvpix_d1;
      hs_d1 <= hsync_in;
      hs_d2 <= hs_d1;
      vs_d1 <= vsync_in;
      vs_d2 <= vs_d1;
      rgb <= hvpix_d2 ? cram_rdata : '0;
      hsync <= hs_d2;
      vsync <= vs_d2;
      blank <= !hvpix_d2;
    end
  end

endmodule

// ==== rtl/video_top.sv ====
`include "video_settings.svh"

module video_top
  import video_cfg_pkg::*;
  import video_pix_pkg::*;
(
  input  logic                clk,
  input  logic                rst,

  // port registers
  input  logic                port_wr,
  input  logic [`PORT_AW-1:0] port_a,
  input  logic [7:0]          d,

  // line buffers and colour RAM
  input  logic                lbuf_we,
  input  logic                cram_we,
  input  logic [8:0]          zma,
  input  logic [15:0]         zmd,

  output logic [4:0]          red,
  output logic [4:0]          grn,
  output logic [4:0]          blu,
  output logic                hsync,
  output logic                vsync,
  output logic                blank
);

  pix_idx_t                     border;
  plane_cfg_t [`NUM_PLANES-1:0] cfg;
  logic [`NUM_PLANES-1:0]       lb_we;
  logic [7:0]                   lb_addr;
  pix_idx_t                     lb_data;
  pix_idx_t [`NUM_PLANES-1:0]   pix;
  logic [`NUM_PLANES-1:0]       hit;
  logic                         hs_raw;
  logic                         vs_raw;
  rgb15_t                       rgb;

  video_timing_if tim ();

  video_sync i_sync (
    .clk   (clk),
    .rst   (rst),
    .tim   (tim.src),
    .hsync (hs_raw),
    .vsync (vs_raw)
  );

  video_ports i_ports (
    .clk     (clk),
    .rst     (rst),
    .port_wr (port_wr),
    .port_a  (port_a),
    .d       (d),
    .lbuf_we (lbuf_we),
    .zma     (zma),
    .zmd     (zmd),
    .border  (border),
    .cfg     (cfg),
    .lb_we   (lb_we),
    .lb_addr (lb_addr),
    .lb_data (lb_data)
  );

  for (genvar i = 0; i < `NUM_PLANES; i++) begin : g_plane
    video_plane #(
      .PLANE_ID (i)
    ) i_plane (
      .clk     (clk),
      .rst     (rst),
      .tim     (tim.dst),
      .cfg     (cfg[i]),
      .lb_we   (lb_we[i]),
      .lb_addr (lb_addr),
      .lb_data (lb_data),
      .pix     (pix[i]),
      .hit     (hit[i])
    );
  end

  // colour RAM entry is 15 bits of zmd
  video_mix i_mix (
    .clk       (clk),
    .rst       (rst),
    .tim       (tim.dst),
    .pix       (pix),
    .hit       (hit),
    .border    (border),
    .hsync_in  (hs_raw),
    .vsync_in  (vs_raw),
    .cram_we   (cram_we),
    .cram_addr (zma[7:0]),
    .cram_data (rgb15_t'(zmd[14:0])),
    .rgb       (rgb),
    .hsync     (hsync),
    .vsync     (vsync),
    .blank     (blank)
  );

  assign red = rgb.red;
  assign grn = rgb.green;
  assign blu = rgb.blue;

endmodule

// ==== sim/video_checker.sv ====
`include "video_settings.svh"

module video_checker (
  input logic       clk,
  input logic       rst,
  input logic [4:0] red,
  input logic [4:0] grn,
  input logic [4:0] blu,
  input logic       hsync,
  input logic       vsync,
  input logic       blank
);

  timeunit 1ns;
  timeprecision 100ps;

  // colour forced off while blanked
  a_rgb_blank : assert property (
    @(posedge clk) disable iff (rst)
    blank |-> ({red, grn, blu} == 15'h0)
  ) else $error("rgb not zero while blank is high");

  // sync pulse width
  a_hsync_len : assert property (
    @(posedge clk) disable iff (rst)
    $rose(hsync) |-> hsync [*`H_SYNC_LEN] ##1 !hsync
  ) else $error("hsync pulse length differs from H_SYNC_LEN");

  // outputs idle right after reset release
  a_reset_idle : assert property (
    @(posedge clk)
    $fell(rst) |-> (!hsync && !vsync && !blank)
  ) else $error("sync or blank active after reset release");

endmodule

bind video_top video_checker i_checker (.*);

// ==== sim/video_top_tb.sv ====
`include "video_settings.svh"

module video_top_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_CASES = 7;
  localparam int FRAME = `H_TOTAL * `V_TOTAL;
  localparam int LIMIT = (N_CASES + 2) * FRAME + 4000;

  typedef struct {
    string           name;
    logic [1:0][7:0] x_offs;
    logic [1:0]      en;
    logic [1:0][3:0] pal;
    logic [7:0]      border;
    bit              mid;
  } case_t;

  // per-plane fields hold plane 1 first
  case_t cases [N_CASES] = '{
    '{"planes_off",     {8'd0, 8'd0},    2'b00, {4'd0, 4'd0},   8'h5a, 1'b0},
    '{"plane1_only",    {8'd0, 8'd0},    2'b10, {4'd3, 4'd0},   8'h21, 1'b0},
    '{"scroll_p1",      {8'd37, 8'd0},   2'b10, {4'd9, 4'd0},   8'h77, 1'b0},
    '{"scroll_p0",      {8'd0, 8'd200},  2'b01, {4'd0, 4'd6},   8'h10, 1'b0},
    '{"priority",       {8'd250, 8'd13}, 2'b11, {4'd4, 4'd2},   8'hc3, 1'b0},
    '{"priority_same",  {8'd0, 8'd0},    2'b11, {4'd5, 4'd5},   8'h00, 1'b0},
    '{"mid_line_write", {8'd7, 8'd99},   2'b11, {4'd14, 4'd11}, 8'h3e, 1'b1}
  };

  logic        clk;
  logic        rst;
  logic        port_wr;
  logic [3:0]  port_a;
  logic [7:0]  d;
  logic        lbuf_we;
  logic        cram_we;
  logic [8:0]  zma;
  logic [15:0] zmd;
  logic [4:0]  red;
  logic [4:0]  grn;
  logic [4:0]  blu;
  logic        hsync;
  logic        vsync;
  logic        blank;

  // host side copies of everything written
  logic [7:0]  lbuf_model [2][256];
  logic [14:0] cram_model [256];
  logic [7:0]  m_border;
  logic [7:0]  m_x [2];
  logic        m_en [2];
  logic [3:0]  m_pal [2];

  int cycles = 0;
  int tests_run = 0;
  int tests_failed = 0;

  video_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .port_wr (port_wr),
    .port_a  (port_a),
    .d       (d),
    .lbuf_we (lbuf_we),
    .cram_we (cram_we),
    .zma     (zma),
    .zmd     (zmd),
    .red     (red),
    .grn     (grn),
    .blu     (blu),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank   (blank)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_memories();
    logic [7:0] px;
    for (int a = 0; a < 512; a++) begin
      px = 8'($urandom);
      // roughly a quarter transparent
      if ($urandom_range(3) == 0) begin
        px[3:0] = 4'h0;
      end
      lbuf_model[a / 256][a % 256] = px;
      lbuf_we = 1'b1;
      zma = 9'(a);
      zmd = {8'h00, px};
      step();
    end
    lbuf_we = 1'b0;
    for (int a = 0; a < 256; a++) begin
      cram_model[a] = 15'($urandom);
      cram_we = 1'b1;
      zma = 9'(a);
      zmd = {1'b0, cram_model[a]};
      step();
    end
    cram_we = 1'b0;
  endtask

  // first enabled, non-transparent plane in index order, else border
  function automatic logic [14:0] expected_rgb(int col);
    logic [7:0] sel;
    logic [3:0] nib;
    bit         found;
    sel = m_border;
    found = 1'b0;
    for (int p = 0; p < 2; p++) begin
      nib = lbuf_model[p][(col + m_x[p]) % 256][3:0];
      if (!found && m_en[p] && nib != 4'h0) begin
        sel = {m_pal[p], nib};
        found = 1'b1;
      end
    end
    return cram_model[sel];
  endfunction

  // k: 0 border, then scroll and control per plane
  task automatic drive_reg_write(int ci, int k);
    int p;
    p = (k - 1) / 2;
    port_wr = 1'b1;
    if (k == 0) begin
      port_a = 4'd0;
      d = cases[ci].border;
    end else if (k % 2 == 1) begin
      port_a = 4'(2 + 2 * p);
      d = cases[ci].x_offs[p];
    end else begin
      port_a = 4'(3 + 2 * p);
      d = {cases[ci].en[p], 3'b000, cases[ci].pal[p]};
    end
  endtask

  task automatic load_model(int ci);
    m_border = cases[ci].border;
    for (int p = 0; p < 2; p++) begin
      m_x[p] = cases[ci].x_offs[p];
      m_en[p] = cases[ci].en[p];
      m_pal[p] = cases[ci].pal[p];
    end
  endtask

  task automatic wait_blank_rise();
    while (blank) step();
    while (!blank) step();
  endtask

  task automatic wait_blank_fall();
    while (blank) step();
  endtask

  // starts on the cycle that shows column 0, ends at the blank rise
  task automatic check_line(int ci, bit with_writes, inout int bad);
    logic [14:0] exp_v;
    logic [14:0] act;
    for (int i = 0; i < `LINE_W; i++) begin
      exp_v = expected_rgb(i);
      act = {red, grn, blu};
      if (blank) begin
        if (bad < 4) begin
          $display("%s: blank was high inside the active line at column %0d",
                   cases[ci].name, i);
        end
        bad++;
      end else if (act !== exp_v) begin
        if (bad < 4) begin
          $display("error: %s col %0d expected %h actual %h",
                   cases[ci].name, i, exp_v, act);
        end
        bad++;
      end
      if (with_writes && i >= 100 && i < 105) begin
        drive_reg_write(ci, i - 100);
      end else begin
        port_wr = 1'b0;
      end
      step();
    end
  endtask

  task automatic run_case(int ci);
    int bad;
    bad = 0;
    if (!cases[ci].mid) begin
      for (int k = 0; k < 5; k++) begin
        drive_reg_write(ci, k);
        step();
      end
      port_wr = 1'b0;
      load_model(ci);
      wait_blank_fall();
      check_line(ci, 1'b0, bad);
    end else begin
      // old settings hold until the next line
      wait_blank_fall();
      check_line(ci, 1'b1, bad);
      load_model(ci);
      wait_blank_fall();
      check_line(ci, 1'b0, bad);
    end
    tests_run++;
    if (bad == 0) begin
      $display("test %s ok", cases[ci].name);
    end else begin
      $display("test %s failed with %0d bad pixels", cases[ci].name, bad);
      tests_failed++;
    end
  endtask

  // one frame from vsync rise to vsync rise
  task automatic check_blanking();
    int   lines;
    int   bad;
    bit   done;
    logic hs_prev;
    logic vs_prev;
    lines = 0;
    bad = 0;
    done = 1'b0;
    while (vsync) step();
    while (!vsync) step();
    hs_prev = hsync;
    vs_prev = 1'b1;
    while (!done) begin
      step();
      if (hsync && !hs_prev) begin
        lines++;
      end
      if (blank && {red, grn, blu} != 15'h0) begin
        bad++;
      end
      if (vsync && !vs_prev) begin
        done = 1'b1;
      end
      hs_prev = hsync;
      vs_prev = vsync;
    end
    if (lines != `V_TOTAL) begin
      $display("error: blanking lines per frame expected %0d actual %0d", `V_TOTAL, lines);
      bad++;
    end
    tests_run++;
    if (bad == 0) begin
      $display("test blanking ok");
    end else begin
      $display("test blanking failed, rgb not zero in blank or wrong frame length");
      tests_failed++;
    end
  endtask

  initial begin
    rst = 1'b1;
    port_wr = 1'b0;
    port_a = 4'd0;
    d = 8'h00;
    lbuf_we = 1'b0;
    cram_we = 1'b0;
    zma = 9'd0;
    zmd = 16'h0000;
    void'($urandom(84));
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fill_memories();
    wait_blank_rise();
    for (int ci = 0; ci < N_CASES; ci++) begin
      run_case(ci);
    end
    check_blanking();
    $display("tests %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/video_cfg_pkg.sv
rtl/video_pix_pkg.sv
rtl/video_timing_if.sv
rtl/video_dpram.sv
rtl/video_sync.sv
rtl/video_ports.sv
rtl/video_plane.sv
rtl/video_mix.sv
rtl/video_top.sv
sim/video_checker.sv
sim/video_top_tb.sv
